// ==== compile.f ====
+incdir+include
hw/decodePkg.sv
hw/pipeStage.sv
hw/opcodeClassifier.sv
hw/formDecoder.sv
hw/instrDecoder.sv
tests/instrDecoderTb.sv

// ==== Bender.yml ====
package:
  name: instr_decoder

sources:
  - hw/decodePkg.sv
  - hw/pipeStage.sv
  - hw/opcodeClassifier.sv
  - hw/formDecoder.sv
  - hw/instrDecoder.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/instrDecoderTb.sv

// ==== include/decodeModel.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// field register code, special for R0, R1 and R15
function automatic decodePkg::regId_t refReg(input logic [3:0] field, input logic ext);
	return {((field[3:1] == 3'b000) || (field == 4'hF)), ext, field};
endfunction

// expected result packed as {regN, regM, regO, imm, uCmd, uIxt}
function automatic logic [decodePkg::decodedWidth-1:0] decodeRef(
	input decodePkg::instrWord_t word
);
	logic [7:0] hi;
	logic [5:0] op;
	logic [1:0] cc;
	logic [5:0] ix;
	logic [2:0] sz;
	logic [3:0] base;
	logic load;
	decodePkg::regId_t rn;
	decodePkg::regId_t rm;
	decodePkg::regId_t ro;
	decodePkg::immVal_t imm;
	decodePkg::uIxt_t ixt;
	hi = word[15:8];
	op = decodePkg::INVOP;
	cc = decodePkg::AL;
	ix = '0;
	rn = decodePkg::REG_ZZR;
	rm = decodePkg::REG_ZZR;
	ro = decodePkg::REG_ZZR;
	imm = '0;
	ixt = '0;
	if (word == 16'h0000) begin
		op = decodePkg::NOP;
	end else if (hi < 8'h10) begin
		load = hi[3];
		sz = {1'b0, hi[1:0]};
		base = load ? word[3:0] : word[7:4];
		op = load ? decodePkg::MOV_MR : decodePkg::MOV_RM;
		rn = refReg(load ? word[7:4] : word[3:0], 1'b0);
		rm = refReg(base, 1'b0);
		ro = hi[2] ? decodePkg::REG_DLR : decodePkg::REG_ZZR;
		ixt = {cc, sz[1:0], load, sz};
		if (base[3:1] == 3'b000) begin
			rm = base[0] ? decodePkg::REG_GBR : decodePkg::REG_PC;
			ixt[2:0] = {sz[2], 2'b00};
		end
	end else if (hi < 8'h1F) begin
		ro = decodePkg::REG_DLR;
		rn = refReg(word[7:4], hi == 8'h1A || hi == 8'h1B);
		rm = refReg(word[3:0], hi == 8'h19 || hi == 8'h1B);
		if (hi == 8'h14) begin
			op = decodePkg::ALUCMP;
			ix = decodePkg::TST;
		end else if (hi < 8'h18) begin
			op = decodePkg::ALU3;
			ix = hi[2:0];
			ro = rm;
			rm = rn;
		end else if (hi < 8'h1C) begin
			op = decodePkg::CONV_RR;
			ix = decodePkg::CONV_MOV;
		end else begin
			op = decodePkg::ALUCMP;
			ix = (hi == 8'h1C) ? decodePkg::CMPEQ
				: (hi == 8'h1D) ? decodePkg::CMPHI : decodePkg::CMPGT;
		end
		ixt = {cc, ix};
	end else if (hi >= 8'h20 && hi < 8'h24) begin
		op = (hi == 8'h21) ? decodePkg::BSR : decodePkg::BRA;
		cc = (hi == 8'h22) ? decodePkg::CT : (hi == 8'h23) ? decodePkg::CF : decodePkg::AL;
		rn = decodePkg::REG_DLR;
		rm = decodePkg::REG_PC;
		ro = decodePkg::REG_IMM;
		imm = {{25{word[7]}}, word[7:0]};
		ixt = {cc, 2'b01, 1'b1, decodePkg::BTY_SW};
	end else if (hi >= 8'h24 && hi < 8'h27) begin
		op = decodePkg::MOV_IR;
		rn = decodePkg::REG_DLR;
		rm = decodePkg::REG_IMM;
		imm = {{25{hi == 8'h25}}, word[7:0]};
	end else if (hi == 8'h30) begin
		op = decodePkg::OP_IXT;
		case (word[7:0])
			8'h00: op = decodePkg::NOP;
			8'h10, 8'h12: op = decodePkg::JMP;
			8'h20: ix = decodePkg::SLEEP;
			8'h30: ix = decodePkg::BREAK;
			8'h40: ix = decodePkg::CLRT;
			8'h50: ix = decodePkg::SETT;
			8'h60: ix = decodePkg::CLRS;
			8'h70: ix = decodePkg::SETS;
			8'h80: ix = decodePkg::NOTT;
			8'h90: ix = decodePkg::NOTS;
			8'hC0: ix = decodePkg::RTE;
			8'hA0, 8'hB0: begin
				op = decodePkg::MOV_IR;
				ix = decodePkg::LDISH16;
			end
			default: op = decodePkg::INVOP;
		endcase
		if (op == decodePkg::JMP) begin
			rm = decodePkg::REG_LR;
		end
		if (word == 16'h30B0) begin
			imm = 33'h0_0000_FFFF;
		end
		if (op != decodePkg::INVOP) begin
			ixt = {cc, ix};
		end
	end else if (word[15:13] == 3'b101) begin
		// 0xA zero-extends, 0xB ones-extends
		op = decodePkg::MOV_IR;
		rn = decodePkg::REG_DLR;
		rm = decodePkg::REG_IMM;
		imm = {{21{word[12]}}, word[11:0]};
	end else if (word[15:13] == 3'b110) begin
		op = word[12] ? decodePkg::MOV_IR : decodePkg::ALU3;
		ix = decodePkg::ADD;
		rn = refReg(word[11:8], 1'b0);
		rm = decodePkg::REG_IMM;
		ro = rn;
		imm = {{25{word[7]}}, word[7:0]};
		ixt = {cc, ix};
	end
	return {rn, rm, ro, imm, cc, op, ixt};
endfunction

`endif

// ==== tests/instrDecoderTb.sv ====
module instrDecoderTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int randomCount = 400;

	logic clock;
	logic rstN;
	logic instrValid;
	decodePkg::instrWord_t instrWord;
	logic instrReady;
	logic outValid;
	logic outReady;
	decodePkg::regId_t regN;
	decodePkg::regId_t regM;
	decodePkg::regId_t regO;
	decodePkg::immVal_t imm;
	decodePkg::uCmd_t uCmd;
	decodePkg::uIxt_t uIxt;

	// scoreboard, one entry per accepted word
	decodePkg::instrWord_t stimQ[$];
	decodePkg::instrWord_t expectQ[$];
	int acceptQ[$];
	logic strictQ[$];
	logic strict;
	int cycle = 0;
	int plannedWords = 0;

	`include "decodeModel.svh"

	instrDecoder instrDecoder_i (
		.clock(clock), .rstN(rstN),
		.instrValid(instrValid), .instrWord(instrWord), .instrReady(instrReady),
		.outValid(outValid), .outReady(outReady),
		.regN(regN), .regM(regM), .regO(regO),
		.imm(imm), .uCmd(uCmd), .uIxt(uIxt)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	task automatic stopOnError(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic checkReg(input string name, input decodePkg::instrWord_t word,
		input decodePkg::regId_t got, input decodePkg::regId_t exp);
		if (got !== exp) begin
			stopOnError($sformatf("MISMATCH %s: word %h got %h expected %h", name, word, got, exp));
		end
	endtask

	task automatic checkImm(input decodePkg::instrWord_t word,
		input decodePkg::immVal_t got, input decodePkg::immVal_t exp);
		if (got !== exp) begin
			stopOnError($sformatf("MISMATCH imm: word %h got %h expected %h", word, got, exp));
		end
	endtask

	task automatic checkCmd(input decodePkg::instrWord_t word,
		input decodePkg::uCmd_t gotCmd, input decodePkg::uCmd_t expCmd,
		input decodePkg::uIxt_t gotIxt, input decodePkg::uIxt_t expIxt);
		if (gotCmd !== expCmd) begin
			stopOnError($sformatf("MISMATCH uCmd: word %h got %h expected %h",
				word, gotCmd, expCmd));
		end else if (gotIxt !== expIxt) begin
			stopOnError($sformatf("MISMATCH uIxt: word %h got %h expected %h",
				word, gotIxt, expIxt));
		end
	endtask

	// encodings that the table keeps
	function automatic logic isKept(input decodePkg::instrWord_t w);
		logic [7:0] hi;
		hi = w[15:8];
		if (hi <= 8'h1E || (hi >= 8'h20 && hi <= 8'h26)) begin
			return 1'b1;
		end
		if (w[15:12] >= 4'hA && w[15:12] <= 4'hD) begin
			return 1'b1;
		end
		if (hi == 8'h30) begin
			return (w[7:0] == 8'h12) || (w[3:0] == 4'h0 && w[7:4] <= 4'hC);
		end
		return 1'b0;
	endfunction

	// fields 0, 1 and 15 first, then a random one
	function automatic logic [3:0] nibblePick(input int k);
		case (k)
			0: return 4'h0;
			1: return 4'h1;
			2: return 4'hF;
			default: return 4'($urandom);
		endcase
	endfunction

	function automatic logic [11:0] immPick(input int k);
		case (k)
			0: return 12'h000;
			1: return 12'hFFF;
			2: return 12'h7FF;
			3: return 12'h800;
			4: return 12'h07F;
			5: return 12'h080;
			default: return 12'($urandom);
		endcase
	endfunction

	task automatic buildDirected();
		logic [11:0] low;
		decodePkg::instrWord_t w;
		// memory, ALU, move and compare groups
		for (int hi = 0; hi <= 8'h1E; hi++) begin
			for (int a = 0; a < 4; a++) begin
				for (int b = 0; b < 4; b++) begin
					stimQ.push_back({8'(hi), nibblePick(a), nibblePick(b)});
				end
			end
		end
		for (int hi = 8'h20; hi <= 8'h26; hi++) begin
			for (int k = 0; k < 8; k++) begin
				low = immPick(k);
				stimQ.push_back({8'(hi), low[7:0]});
			end
		end
		for (int op = 4'hA; op <= 4'hD; op++) begin
			for (int k = 0; k < 12; k++) begin
				stimQ.push_back({4'(op), immPick(k)});
			end
		end
		for (int k = 0; k <= 12; k++) begin
			stimQ.push_back(16'h3000 + 16'(k * 16));
		end
		stimQ.push_back(16'h3012);
		stimQ.push_back(16'h3001);
		stimQ.push_back(16'h3011);
		stimQ.push_back(16'h30D0);
		stimQ.push_back(16'h30FF);
		repeat (40) begin
			do begin
				w = 16'($urandom);
			end while (isKept(w));
			stimQ.push_back(w);
		end
	endtask

	// called a step after an edge, returns a step after the accepting edge
	task automatic sendWord(input decodePkg::instrWord_t word);
		logic accepted;
		accepted = 1'b0;
		instrValid = 1'b1;
		instrWord = word;
		while (!accepted) begin
			@(posedge clock);
			accepted = instrReady;
			if (accepted) begin
				expectQ.push_back(word);
				acceptQ.push_back(cycle);
				strictQ.push_back(strict);
			end else if (strict) begin
				stopOnError($sformatf("instrReady low with outReady held high, word %h", word));
			end
			#1;
			if (!strict) begin
				outReady = 1'($urandom);
			end
		end
	endtask

	task automatic drainPipe();
		instrValid = 1'b0;
		outReady = 1'b1;
		while (expectQ.size() != 0) begin
			@(negedge clock);
		end
		@(posedge clock);
		#1;
	endtask

	always @(posedge clock) begin : compareResult
		decodePkg::instrWord_t word;
		decodePkg::regId_t expN;
		decodePkg::regId_t expM;
		decodePkg::regId_t expO;
		decodePkg::immVal_t expImm;
		decodePkg::uCmd_t expCmd;
		decodePkg::uIxt_t expIxt;
		int acceptedAt;
		logic timed;
		if (rstN && outValid && outReady) begin
			if (expectQ.size() == 0) begin
				stopOnError("a result came out with no instruction pending");
			end else begin
				word = expectQ.pop_front();
				acceptedAt = acceptQ.pop_front();
				timed = strictQ.pop_front();
				{expN, expM, expO, expImm, expCmd, expIxt} = decodeRef(word);
				checkReg("regN", word, regN, expN);
				checkReg("regM", word, regM, expM);
				checkReg("regO", word, regO, expO);
				checkImm(word, imm, expImm);
				checkCmd(word, uCmd, expCmd, uIxt, expIxt);
				if (timed && cycle - acceptedAt != 2) begin
					stopOnError($sformatf("word %h came out %0d cycles after acceptance, not 2",
						word, cycle - acceptedAt));
				end
			end
		end
	end

	initial begin
		decodePkg::instrWord_t w;
		clock = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instrWord = '0;
		outReady = 1'b0;
		strict = 1'b0;
		void'($urandom(32'h469a_9126));
		buildDirected();
		plannedWords = stimQ.size() + randomCount;
		repeat (8) @(posedge clock);
		#1;
		rstN = 1'b1;
		outReady = 1'b1;
		// back-to-back stream, fixed two-cycle latency
		strict = 1'b1;
		foreach (stimQ[i]) begin
			sendWord(stimQ[i]);
		end
		drainPipe();
		strict = 1'b0;
		repeat (randomCount) begin
			if (1'($urandom)) begin
				w = 16'($urandom);
			end else begin
				w = stimQ[$urandom % stimQ.size()];
			end
			sendWord(w);
		end
		drainPipe();
		repeat (4) @(negedge clock);
		if (expectQ.size() == 0 && !outValid) begin
			$display("TEST PASS");
			$finish;
		end else begin
			stopOnError("results were still pending after the last instruction");
		end
	end

	// up to 20 cycles per instruction plus the reset
	initial begin
		wait (plannedWords != 0);
		#((plannedWords * 20 + 8) * 10);
		stopOnError("timeout, the decoder stopped delivering results");
	end

endmodule

// ==== hw/instrDecoder.sv ====
module instrDecoder (
	input logic clock,
	input logic rstN,
	input logic instrValid,
	input decodePkg::instrWord_t instrWord,
	output logic instrReady,
	output logic outValid,
	input logic outReady,
	output decodePkg::regId_t regN,
	output decodePkg::regId_t regM,
	output decodePkg::regId_t regO,
	output decodePkg::immVal_t imm,
	output decodePkg::uCmd_t uCmd,
	output decodePkg::uIxt_t uIxt
);

	decodePkg::majorOp_e majorOp;
	decodePkg::formId_e formId;
	decodePkg::bty_t bty;
	decodePkg::ity_e ity;
	decodePkg::ccty_e ccty;
	decodePkg::ucmdIx_t ucmdIx;

	logic [decodePkg::classifiedWidth-1:0] classIn;
	logic [decodePkg::classifiedWidth-1:0] classOut;
	logic classValid;
	logic classReady;

	decodePkg::regId_t decN;
	decodePkg::regId_t decM;
	decodePkg::regId_t decO;
	decodePkg::immVal_t decImm;
	decodePkg::uCmd_t decCmd;
	decodePkg::uIxt_t decIxt;
	logic [decodePkg::decodedWidth-1:0] resultOut;

	opcodeClassifier opcodeClassifier_i (
		.instrWord(instrWord), .majorOp(majorOp), .formId(formId),
		.bty(bty), .ity(ity), .ccty(ccty), .ucmdIx(ucmdIx)
	);

	assign classIn = {majorOp, formId, bty, ity, ccty, ucmdIx, instrWord};

	pipeStage #(.width(decodePkg::classifiedWidth)) classifyStage (
		.clock(clock), .rstN(rstN),
		.inValid(instrValid), .inReady(instrReady), .inData(classIn),
		.outValid(classValid), .outReady(classReady), .outData(classOut)
	);

	// word in [15:0], classification packed above it
	formDecoder formDecoder_i (
		.instrWord(classOut[15:0]),
		.majorOp(decodePkg::majorOp_e'(classOut[41:36])),
		.formId(decodePkg::formId_e'(classOut[35:31])),
		.bty(classOut[30:28]),
		.ity(decodePkg::ity_e'(classOut[27:24])),
		.ccty(decodePkg::ccty_e'(classOut[23:22])),
		.ucmdIx(classOut[21:16]),
		.regN(decN), .regM(decM), .regO(decO),
		.imm(decImm), .uCmd(decCmd), .uIxt(decIxt)
	);

	// an invalid form reaches the form decoder only as an invalid op
	invopOnInvalidForm: assert property (
		@(posedge clock) disable iff (!rstN)
		classValid && classOut[35:31] == decodePkg::INV |-> classOut[41:36] == decodePkg::INVOP
	);

	pipeStage #(.width(decodePkg::decodedWidth)) resultStage (
		.clock(clock), .rstN(rstN),
		.inValid(classValid), .inReady(classReady),
		.inData({decN, decM, decO, decImm, decCmd, decIxt}),
		.outValid(outValid), .outReady(outReady), .outData(resultOut)
	);

	assign {regN, regM, regO, imm, uCmd, uIxt} = resultOut;

endmodule

// ==== hw/formDecoder.sv ====
module formDecoder (
	input decodePkg::instrWord_t instrWord,
	input decodePkg::majorOp_e majorOp,
	input decodePkg::formId_e formId,
	input decodePkg::bty_t bty,
	input decodePkg::ity_e ity,
	input decodePkg::ccty_e ccty,
	input decodePkg::ucmdIx_t ucmdIx,
	output decodePkg::regId_t regN,
	output decodePkg::regId_t regM,
	output decodePkg::regId_t regO,
	output decodePkg::immVal_t imm,
	output decodePkg::uCmd_t uCmd,
	output decodePkg::uIxt_t uIxt
);

	// special bit marks fields 0, 1 and 15
	function automatic decodePkg::regId_t regCode(input logic [3:0] field, input logic ext);
		logic special;
		special = (field[3:1] == 3'b000) || (field == 4'hF);
		return {special, ext, field};
	endfunction

	decodePkg::regId_t oDfl;
	decodePkg::regId_t nDfl;
	decodePkg::regId_t mDfl;
	decodePkg::regId_t nExt;
	decodePkg::regId_t mExt;
	logic isLoad;
	logic isDr;
	logic [3:0] baseField;
	logic [24:0] sext8;

	assign oDfl = regCode(instrWord[11:8], 1'b0);
	assign nDfl = regCode(instrWord[7:4], 1'b0);
	assign mDfl = regCode(instrWord[3:0], 1'b0);
	assign nExt = regCode(instrWord[7:4], 1'b1);
	assign mExt = regCode(instrWord[3:0], 1'b1);

	assign uCmd = {ccty, majorOp};

	assign isLoad = (formId == decodePkg::LDREGREG) || (formId == decodePkg::LDDRREGREG);
	assign isDr = (formId == decodePkg::REGSTDRREG) || (formId == decodePkg::LDDRREGREG);
	// stores take the base from [7:4], loads from [3:0]
	assign baseField = isLoad ? instrWord[3:0] : instrWord[7:4];
	assign sext8 = {25{instrWord[7]}};

	always_comb begin
		regN = decodePkg::REG_ZZR;
		regM = decodePkg::REG_ZZR;
		regO = decodePkg::REG_ZZR;
		imm = '0;
		uIxt = '0;

		case (formId)
			decodePkg::Z: begin
				uIxt = {ccty, ucmdIx};
				if (instrWord == 16'h3010 || instrWord == 16'h3012) begin
					regM = decodePkg::REG_LR;
				end
				if (instrWord == 16'h30B0) begin
					imm = 33'h0_0000_FFFF;
				end
			end
			decodePkg::REGREG: begin
				uIxt = {ccty, ucmdIx};
				regO = decodePkg::REG_DLR;
				case (ity)
					decodePkg::SW: begin
						regN = nDfl;
						regM = mExt;
					end
					decodePkg::SL: begin
						regN = nExt;
						regM = mDfl;
					end
					decodePkg::SQ: begin
						regN = nExt;
						regM = mExt;
					end
					// three-operand, Rn op Rm into Rn
					decodePkg::NB: begin
						regN = nDfl;
						regM = nDfl;
						regO = mDfl;
					end
					default: begin
						regN = nDfl;
						regM = mDfl;
					end
				endcase
			end
			decodePkg::REGSTREG, decodePkg::REGSTDRREG,
			decodePkg::LDREGREG, decodePkg::LDDRREGREG: begin
				regN = isLoad ? nDfl : mDfl;
				regM = isLoad ? mDfl : nDfl;
				if (isDr) begin
					regO = decodePkg::REG_DLR;
				end
				uIxt = {ccty, bty[1:0], isLoad, bty};
				// base R0 means PC, R1 means GBR
				if (baseField[3:1] == 3'b000) begin
					regM = baseField[0] ? decodePkg::REG_GBR : decodePkg::REG_PC;
					uIxt[2:0] = {bty[2], 2'b00};
				end
			end
			decodePkg::PCDISP8: begin
				regN = decodePkg::REG_DLR;
				regM = decodePkg::REG_PC;
				regO = decodePkg::REG_IMM;
				imm = {sext8, instrWord[7:0]};
				uIxt = {ccty, bty[1:0], 1'b1, bty};
			end
			decodePkg::IMM8Z, decodePkg::IMM8N: begin
				regN = decodePkg::REG_DLR;
				regM = decodePkg::REG_IMM;
				imm = {{25{formId == decodePkg::IMM8N}}, instrWord[7:0]};
			end
			decodePkg::IMM12Z, decodePkg::IMM12N: begin
				regN = decodePkg::REG_DLR;
				regM = decodePkg::REG_IMM;
				imm = {{21{formId == decodePkg::IMM12N}}, instrWord[11:0]};
			end
			decodePkg::IMM8REG: begin
				regN = oDfl;
				regM = decodePkg::REG_IMM;
				regO = oDfl;
				imm = {sext8, instrWord[7:0]};
				uIxt = {ccty, ucmdIx};
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== hw/opcodeClassifier.sv ====
module opcodeClassifier (
	input decodePkg::instrWord_t instrWord,
	output decodePkg::majorOp_e majorOp,
	output decodePkg::formId_e formId,
	output decodePkg::bty_t bty,
	output decodePkg::ity_e ity,
	output decodePkg::ccty_e ccty,
	output decodePkg::ucmdIx_t ucmdIx
);

	always_comb begin
		majorOp = decodePkg::INVOP;
		formId = decodePkg::INV;
		bty = decodePkg::BTY_SB;
		ity = decodePkg::SB;
		ccty = decodePkg::AL;
		ucmdIx = '0;

		casez (instrWord[15:8])
			// stores, bit 10 selects the DLR-indexed form
			8'b0000_0???: begin
				majorOp = decodePkg::MOV_RM;
				formId = instrWord[10] ? decodePkg::REGSTDRREG : decodePkg::REGSTREG;
				bty = decodePkg::bty_t'({1'b0, instrWord[9:8]});
				if (instrWord == 16'h0000) begin
					majorOp = decodePkg::NOP;
					formId = decodePkg::Z;
				end
			end
			8'b0000_1???: begin
				majorOp = decodePkg::MOV_MR;
				formId = instrWord[10] ? decodePkg::LDDRREGREG : decodePkg::LDREGREG;
				bty = decodePkg::bty_t'({1'b0, instrWord[9:8]});
			end
			8'b0001_0???: begin
				majorOp = decodePkg::ALU3;
				formId = decodePkg::REGREG;
				ity = decodePkg::NB;
				case (instrWord[10:8])
					3'd0: ucmdIx = decodePkg::ADD;
					3'd1: ucmdIx = decodePkg::SUB;
					3'd2: ucmdIx = decodePkg::ADC;
					3'd3: ucmdIx = decodePkg::SBB;
					3'd4: begin
						// TST only updates the flag
						majorOp = decodePkg::ALUCMP;
						ity = decodePkg::SB;
						ucmdIx = decodePkg::TST;
					end
					3'd5: ucmdIx = decodePkg::AND;
					3'd6: ucmdIx = decodePkg::OR;
					default: ucmdIx = decodePkg::XOR;
				endcase
			end
			// register moves, low opcode bits pick the bank routing
			8'b0001_10??: begin
				majorOp = decodePkg::CONV_RR;
				formId = decodePkg::REGREG;
				ity = decodePkg::ity_e'({2'b00, instrWord[9:8]});
				ucmdIx = decodePkg::CONV_MOV;
			end
			8'h1C, 8'h1D, 8'h1E: begin
				majorOp = decodePkg::ALUCMP;
				formId = decodePkg::REGREG;
				case (instrWord[9:8])
					2'd0: ucmdIx = decodePkg::CMPEQ;
					2'd1: ucmdIx = decodePkg::CMPHI;
					default: ucmdIx = decodePkg::CMPGT;
				endcase
			end
			8'b0010_00??: begin
				majorOp = (instrWord[9:8] == 2'd1) ? decodePkg::BSR : decodePkg::BRA;
				formId = decodePkg::PCDISP8;
				bty = decodePkg::BTY_SW;
				if (instrWord[9]) begin
					ccty = instrWord[8] ? decodePkg::CF : decodePkg::CT;
				end
			end
			8'h24, 8'h25, 8'h26: begin
				majorOp = decodePkg::MOV_IR;
				formId = (instrWord[9:8] == 2'd1) ? decodePkg::IMM8N : decodePkg::IMM8Z;
				ucmdIx = instrWord[9] ? decodePkg::LDISH8 : decodePkg::LDIX;
			end
			// fixed no-operand ops, whole word matched
			8'h30: begin
				majorOp = decodePkg::OP_IXT;
				formId = decodePkg::Z;
				case (instrWord[7:0])
					8'h00: majorOp = decodePkg::NOP;
					8'h10, 8'h12: majorOp = decodePkg::JMP;
					8'h20: ucmdIx = decodePkg::SLEEP;
					8'h30: ucmdIx = decodePkg::BREAK;
					8'h40: ucmdIx = decodePkg::CLRT;
					8'h50: ucmdIx = decodePkg::SETT;
					8'h60: ucmdIx = decodePkg::CLRS;
					8'h70: ucmdIx = decodePkg::SETS;
					8'h80: ucmdIx = decodePkg::NOTT;
					8'h90: ucmdIx = decodePkg::NOTS;
					8'hC0: ucmdIx = decodePkg::RTE;
					8'hA0, 8'hB0: begin
						majorOp = decodePkg::MOV_IR;
						ucmdIx = decodePkg::LDISH16;
					end
					default: begin
						majorOp = decodePkg::INVOP;
						formId = decodePkg::INV;
					end
				endcase
			end
			8'b1010_????: begin
				majorOp = decodePkg::MOV_IR;
				formId = decodePkg::IMM12Z;
				ucmdIx = decodePkg::LDIX;
			end
			8'b1011_????: begin
				majorOp = decodePkg::MOV_IR;
				formId = decodePkg::IMM12N;
				ucmdIx = decodePkg::LDIX;
			end
			8'b1100_????: begin
				majorOp = decodePkg::ALU3;
				formId = decodePkg::IMM8REG;
				ucmdIx = decodePkg::ADD;
			end
			8'b1101_????: begin
				majorOp = decodePkg::MOV_IR;
				formId = decodePkg::IMM8REG;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== hw/pipeStage.sv ====
module pipeStage #(
	parameter int width = 8
) (
	input logic clock,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input logic [width-1:0] inData,
	output logic outValid,
	input logic outReady,
	output logic [width-1:0] outData
);

	// room when empty or the entry leaves this edge
	assign inReady = !outValid || outReady;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clock) begin
		if (inValid && inReady) begin
			outData <= inData;
		end
	end

	holdWhileStalled: assert property (
		@(posedge clock) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outData)
	);

endmodule

// ==== hw/decodePkg.sv ====
package decodePkg;

	typedef logic [15:0] instrWord_t;
	typedef logic [5:0] regId_t;
	typedef logic [32:0] immVal_t;
	// condition type in [7:6], operation in [5:0]
	typedef logic [7:0] uCmd_t;
	typedef logic [7:0] uIxt_t;
	typedef logic [2:0] bty_t;
	typedef logic [5:0] ucmdIx_t;

	typedef enum logic [5:0] {
		NOP = 6'h00,
		MOV_RM = 6'h01,
		MOV_MR = 6'h02,
		ALU3 = 6'h03,
		ALUCMP = 6'h04,
		CONV_RR = 6'h05,
		BRA = 6'h06,
		BSR = 6'h07,
		MOV_IR = 6'h08,
		JMP = 6'h09,
		OP_IXT = 6'h0A,
		INVOP = 6'h3F
	} majorOp_e;

	typedef enum logic [4:0] {
		INV = 5'd0,
		Z = 5'd1,
		REGREG = 5'd2,
		REGSTREG = 5'd3,
		LDREGREG = 5'd4,
		REGSTDRREG = 5'd5,
		LDDRREGREG = 5'd6,
		PCDISP8 = 5'd7,
		IMM8Z = 5'd8,
		IMM8N = 5'd9,
		IMM8REG = 5'd10,
		IMM12Z = 5'd11,
		IMM12N = 5'd12
	} formId_e;

	// register routing for the two-register forms
	typedef enum logic [3:0] {
		SB = 4'd0,
		SW = 4'd1,
		SL = 4'd2,
		SQ = 4'd3,
		NB = 4'd4
	} ity_e;

	typedef enum logic [1:0] {
		AL = 2'b00,
		CT = 2'b10,
		CF = 2'b11
	} ccty_e;

	localparam bty_t BTY_SB = 3'd0;
	localparam bty_t BTY_SW = 3'd1;
	localparam bty_t BTY_SL = 3'd2;
	localparam bty_t BTY_SQ = 3'd3;

	// alu sub-ops
	localparam ucmdIx_t ADD = 6'h00;
	localparam ucmdIx_t SUB = 6'h01;
	localparam ucmdIx_t ADC = 6'h02;
	localparam ucmdIx_t SBB = 6'h03;
	localparam ucmdIx_t TST = 6'h04;
	localparam ucmdIx_t AND = 6'h05;
	localparam ucmdIx_t OR = 6'h06;
	localparam ucmdIx_t XOR = 6'h07;
	localparam ucmdIx_t CMPEQ = 6'h08;
	localparam ucmdIx_t CMPHI = 6'h09;
	localparam ucmdIx_t CMPGT = 6'h0A;
	localparam ucmdIx_t CMPGE = 6'h0B;

	localparam ucmdIx_t CONV_MOV = 6'h00;

	localparam ucmdIx_t LDIX = 6'h00;
	localparam ucmdIx_t LDISH8 = 6'h01;
	localparam ucmdIx_t LDISH16 = 6'h02;

	// system ops
	localparam ucmdIx_t SLEEP = 6'h00;
	localparam ucmdIx_t BREAK = 6'h01;
	localparam ucmdIx_t CLRT = 6'h02;
	localparam ucmdIx_t SETT = 6'h03;
	localparam ucmdIx_t CLRS = 6'h04;
	localparam ucmdIx_t SETS = 6'h05;
	localparam ucmdIx_t NOTT = 6'h06;
	localparam ucmdIx_t NOTS = 6'h07;
	localparam ucmdIx_t RTE = 6'h08;

	// DLR shares the code of field 0
	localparam regId_t REG_DLR = 6'h20;
	localparam regId_t REG_PC = 6'h22;
	localparam regId_t REG_GBR = 6'h23;
	localparam regId_t REG_LR = 6'h24;
	localparam regId_t REG_IMM = 6'h3D;
	localparam regId_t REG_ZZR = 6'h3E;

	localparam int decodedWidth = 3 * $bits(regId_t) + $bits(immVal_t)
		+ $bits(uCmd_t) + $bits(uIxt_t);

	// classifier result plus the word it came from
	localparam int classifiedWidth = $bits(majorOp_e) + $bits(formId_e) + $bits(bty_t)
		+ $bits(ity_e) + $bits(ccty_e) + $bits(ucmdIx_t) + $bits(instrWord_t);

endpackage
